/* common/cache_settings.svh */
`ifndef CACHE_SETTINGS_SVH
`define CACHE_SETTINGS_SVH

// ##########################################################################
// Tile geometry
// ##########################################################################

`define CACHE_ROWS      16  // Rows per tile, equal to the bits per row.
`define WORD_W          16  // Width of one tile row.
`define ROW_IDX_W       4   // Selects a row or a column inside the tile.
`define ADDR_W          16  // Word address width on the command side.
`define DDR_ADDR_W      28
`define DDR_ADDR_SHIFT  3   // DDR addresses count bytes in groups of eight.

// ##########################################################################
// Command opcodes
// ##########################################################################

`define OP_ROW_READ     3'd1
`define OP_ROW_WRITE    3'd2
`define OP_COL_READ     3'd3
`define OP_COL_WRITE    3'd4
`define OP_FLUSH        3'd5    // Writes back a dirty tile and keeps it resident.

`endif

/* common/cache_pkg.sv */
`default_nettype none

`include "cache_settings.svh"

package cache_pkg;

    // A word address seen either as a flat value for DDR addressing or as the
    // tile tag plus the row inside the tile.
    typedef union packed {
        logic [`ADDR_W-1:0] word;
        struct packed {
            logic [`ADDR_W-`ROW_IDX_W-1:0] tag;
            logic [`ROW_IDX_W-1:0]         row;
        } fields;
    } cache_addr_u;

endpackage

`default_nettype wire

/* cache/tile_mem.sv */
`timescale 1ns/1ps
`default_nettype none

`include "cache_settings.svh"

module tile_mem (
    input  wire                     clk,
    input  wire                     wr_row_en,
    input  wire [`ROW_IDX_W-1:0]    wr_row_idx,
    input  wire [`WORD_W-1:0]       wr_row_data,
    input  wire                     wr_col_en,
    input  wire [`ROW_IDX_W-1:0]    wr_col_idx,
    input  wire [`CACHE_ROWS-1:0]   wr_col_data,
    input  wire [`ROW_IDX_W-1:0]    rd_row_idx,
    input  wire [`ROW_IDX_W-1:0]    rd_col_idx,
    input  wire                     wb_rd_en,
    input  wire [`ROW_IDX_W-1:0]    wb_rd_idx,
    output logic [`WORD_W-1:0]      rd_row_data,
    output logic [`CACHE_ROWS-1:0]  rd_col_data,
    output logic [`WORD_W-1:0]      wb_rd_data
);

    logic [`WORD_W-1:0] mem [`CACHE_ROWS];

    always_ff @(posedge clk) begin
        if (wr_row_en) begin
            mem[wr_row_idx] <= wr_row_data;
        end
        if (wr_col_en) begin
            for (int r = 0; r < `CACHE_ROWS; r++) begin
                mem[r][wr_col_idx] <= wr_col_data[r];    // Bit r of the column lands in row r.
            end
        end
    end

    // ######################################################################
    // Read ports
    // ######################################################################

    always_ff @(posedge clk) begin
        rd_row_data <= mem[rd_row_idx];
        for (int r = 0; r < `CACHE_ROWS; r++) begin
            rd_col_data[r] <= mem[r][rd_col_idx];
        end
    end

    always_ff @(posedge clk) begin
        if (wb_rd_en) begin
            wb_rd_data <= mem[wb_rd_idx];
        end
    end

endmodule

`default_nettype wire

/* cache/ddr_writeback.sv */
`timescale 1ns/1ps
`default_nettype none

`include "cache_settings.svh"

module ddr_writeback (
    input  wire                     clk,
    input  wire                     rst,
    input  wire                     wb_start,
    input  wire cache_pkg::cache_addr_u wb_tag,
    input  wire [`WORD_W-1:0]       wb_rd_data,
    input  wire                     wb_ready,
    output logic                    wb_rd_en,
    output logic [`ROW_IDX_W-1:0]   wb_rd_idx,
    output logic                    wb_valid,
    output logic [`DDR_ADDR_W-1:0]  wb_addr,
    output logic [`WORD_W-1:0]      wb_data,
    output logic                    wb_done
);

    logic                           active;
    logic [`ADDR_W-`ROW_IDX_W-1:0]  tag_q;
    logic [`ROW_IDX_W:0]            issue_cnt;
    logic [`ROW_IDX_W-1:0]          sent_cnt;
    logic                           rd_pend;
    logic [`WORD_W-1:0]             q_data [2];
    logic                           q_wr_ptr;
    logic                           q_rd_ptr;
    logic [1:0]                     q_count;
    logic [1:0]                     occupancy;
    logic                           pop;
    logic                           last_pop;
    cache_pkg::cache_addr_u         head_addr;

    assign wb_valid  = (q_count != 2'd0);
    assign wb_data   = q_data[q_rd_ptr];
    assign pop       = wb_valid && wb_ready;
    assign last_pop  = pop && (sent_cnt == `ROW_IDX_W'(`CACHE_ROWS - 1));
    assign occupancy = q_count + 2'(rd_pend);    // Queued words plus the read on its way.

    // A new read goes out only while it is sure to find a free queue slot.
    assign wb_rd_en  = (wb_start || active) && !issue_cnt[`ROW_IDX_W]
                       && ((occupancy != 2'd2) || pop);
    assign wb_rd_idx = issue_cnt[`ROW_IDX_W-1:0];

    always_comb begin
        head_addr.fields.tag = tag_q;
        head_addr.fields.row = sent_cnt;
    end

    assign wb_addr = `DDR_ADDR_W'(head_addr.word) << `DDR_ADDR_SHIFT;

    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            active    <= 1'b0;
            issue_cnt <= '0;
            sent_cnt  <= '0;
            rd_pend   <= 1'b0;
            q_wr_ptr  <= 1'b0;
            q_rd_ptr  <= 1'b0;
            q_count   <= 2'd0;
            wb_done   <= 1'b0;
        end else begin
            rd_pend <= wb_rd_en;
            wb_done <= last_pop;
            if (wb_start) begin
                active <= 1'b1;
            end else if (last_pop) begin
                active <= 1'b0;
            end
            if (last_pop) begin
                issue_cnt <= '0;
            end else if (wb_rd_en) begin
                issue_cnt <= issue_cnt + 1'b1;
            end
            if (rd_pend) begin
                q_wr_ptr <= ~q_wr_ptr;
            end
            if (pop) begin
                q_rd_ptr <= ~q_rd_ptr;
                sent_cnt <= sent_cnt + 1'b1;    // Wraps to zero after the last row.
            end
            q_count <= q_count + 2'(rd_pend) - 2'(pop);
        end
    end

    always_ff @(posedge clk) begin
        if (wb_start) begin
            tag_q <= wb_tag.fields.tag;
        end
        if (rd_pend) begin
            q_data[q_wr_ptr] <= wb_rd_data;
        end
    end

endmodule

`default_nettype wire

/* cache/cache_ctrl.sv */
`timescale 1ns/1ps
`default_nettype none

`include "cache_settings.svh"

module cache_ctrl (
    input  wire                     clk,
    input  wire                     rst,
    input  wire                     cmd_valid,
    input  wire [2:0]               cmd_op,
    input  wire [`ADDR_W-1:0]       cmd_addr,
    input  wire [`ROW_IDX_W-1:0]    cmd_col,
    input  wire [`WORD_W-1:0]       cmd_row_data,
    input  wire [`CACHE_ROWS-1:0]   cmd_col_data,
    output logic                    cmd_ready,
    output logic                    rsp_valid,
    output logic [`WORD_W-1:0]      rsp_row,
    output logic [`CACHE_ROWS-1:0]  rsp_col,
    input  wire                     rsp_ready,
    output logic                    rd_req_valid,
    output logic [`DDR_ADDR_W-1:0]  rd_req_addr,
    input  wire                     rd_req_ready,
    input  wire                     fill_valid,
    input  wire [`WORD_W-1:0]       fill_data,
    output logic                    wb_start,
    output cache_pkg::cache_addr_u  wb_tag,
    input  wire                     wb_done,
    output logic                    wr_row_en,
    output logic [`ROW_IDX_W-1:0]   wr_row_idx,
    output logic [`WORD_W-1:0]      wr_row_data,
    output logic                    wr_col_en,
    output logic [`ROW_IDX_W-1:0]   wr_col_idx,
    output logic [`CACHE_ROWS-1:0]  wr_col_data,
    output logic [`ROW_IDX_W-1:0]   rd_row_idx,
    output logic [`ROW_IDX_W-1:0]   rd_col_idx,
    input  wire [`WORD_W-1:0]       rd_row_data,
    input  wire [`CACHE_ROWS-1:0]   rd_col_data
);

    localparam logic [2:0] S_IDLE     = 3'd0;
    localparam logic [2:0] S_WB_WAIT  = 3'd1;
    localparam logic [2:0] S_FILL_REQ = 3'd2;
    localparam logic [2:0] S_FILL     = 3'd3;
    localparam logic [2:0] S_ACCESS   = 3'd4;
    localparam logic [2:0] S_RESPOND  = 3'd5;

    logic [2:0]                     state;
    logic                           tile_valid;
    logic                           tile_dirty;
    logic [`ADDR_W-`ROW_IDX_W-1:0]  tile_tag;
    logic [`ROW_IDX_W-1:0]          fill_cnt;
    cache_pkg::cache_addr_u         cmd_a;
    cache_pkg::cache_addr_u         addr_q;
    cache_pkg::cache_addr_u         fill_base;
    logic [2:0]                     op_q;
    logic [`ROW_IDX_W-1:0]          col_q;
    logic [`WORD_W-1:0]             row_data_q;
    logic [`CACHE_ROWS-1:0]         col_data_q;
    logic                           accept;
    logic                           hit;
    logic                           need_wb;
    logic                           op_read;
    logic                           op_write;

    assign cmd_a     = cmd_addr;
    assign accept    = cmd_valid && cmd_ready;
    assign hit       = tile_valid && (cmd_a.fields.tag == tile_tag);
    assign need_wb   = tile_valid && tile_dirty && ((cmd_op == `OP_FLUSH) || !hit);
    assign op_read   = (op_q == `OP_ROW_READ) || (op_q == `OP_COL_READ);
    assign op_write  = (op_q == `OP_ROW_WRITE) || (op_q == `OP_COL_WRITE);
    assign cmd_ready = (state == S_IDLE);
    assign rd_req_valid = (state == S_FILL_REQ);

    always_comb begin
        fill_base.fields.tag = addr_q.fields.tag;
        fill_base.fields.row = '0;
        wb_tag.fields.tag    = tile_tag;
        wb_tag.fields.row    = '0;
    end

    assign rd_req_addr = `DDR_ADDR_W'(fill_base.word) << `DDR_ADDR_SHIFT;

    // ######################################################################
    // Tile port drive
    // ######################################################################

    always_comb begin
        wr_row_en   = (state == S_ACCESS) && (op_q == `OP_ROW_WRITE);
        wr_row_idx  = addr_q.fields.row;
        wr_row_data = row_data_q;
        if (state == S_FILL) begin
            wr_row_en   = fill_valid;    // Each fill beat becomes one row write.
            wr_row_idx  = fill_cnt;
            wr_row_data = fill_data;
        end
    end

    assign wr_col_en   = (state == S_ACCESS) && (op_q == `OP_COL_WRITE);
    assign wr_col_idx  = col_q;
    assign wr_col_data = col_data_q;
    assign rd_row_idx  = addr_q.fields.row;
    assign rd_col_idx  = col_q;

    // ######################################################################
    // Control FSM
    // ######################################################################

    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            state      <= S_IDLE;
            tile_valid <= 1'b0;
            tile_dirty <= 1'b0;
            tile_tag   <= '0;
            fill_cnt   <= '0;
            wb_start   <= 1'b0;
            rsp_valid  <= 1'b0;
        end else begin
            wb_start <= 1'b0;
            case (state)
                S_IDLE: begin
                    if (accept) begin
                        if (need_wb) begin
                            wb_start <= 1'b1;
                            state    <= S_WB_WAIT;
                        end else if (hit || (cmd_op == `OP_FLUSH)) begin
                            state <= S_ACCESS;    // A clean flush has nothing to do.
                        end else begin
                            state <= S_FILL_REQ;
                        end
                    end
                end
                S_WB_WAIT: begin
                    if (wb_done) begin
                        tile_dirty <= 1'b0;
                        state      <= (op_q == `OP_FLUSH) ? S_IDLE : S_FILL_REQ;
                    end
                end
                S_FILL_REQ: begin
                    if (rd_req_ready) begin
                        fill_cnt <= '0;
                        state    <= S_FILL;
                    end
                end
                S_FILL: begin
                    if (fill_valid) begin
                        fill_cnt <= fill_cnt + 1'b1;
                        if (fill_cnt == `ROW_IDX_W'(`CACHE_ROWS - 1)) begin
                            tile_valid <= 1'b1;
                            tile_dirty <= 1'b0;
                            tile_tag   <= addr_q.fields.tag;
                            state      <= S_ACCESS;
                        end
                    end
                end
                S_ACCESS: begin
                    if (op_write) begin
                        tile_dirty <= 1'b1;
                    end
                    state <= op_read ? S_RESPOND : S_IDLE;
                end
                S_RESPOND: begin
                    if (!rsp_valid) begin
                        rsp_valid <= 1'b1;    // Tile read data arrived in the previous cycle.
                    end else if (rsp_ready) begin
                        rsp_valid <= 1'b0;
                        state     <= S_IDLE;
                    end
                end
                default: begin
                    state <= S_IDLE;
                end
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            op_q       <= cmd_op;
            addr_q     <= cmd_a;
            col_q      <= cmd_col;
            row_data_q <= cmd_row_data;
            col_data_q <= cmd_col_data;
        end
        if ((state == S_RESPOND) && !rsp_valid) begin
            rsp_row <= rd_row_data;
            rsp_col <= rd_col_data;
        end
    end

endmodule

`default_nettype wire

/* hdl/data_cache.sv */
`timescale 1ns/1ps
`default_nettype none

`include "cache_settings.svh"

module data_cache (
    input  wire                     clk,
    input  wire                     rst,
    input  wire                     cmd_valid,
    input  wire [2:0]               cmd_op,
    input  wire [`ADDR_W-1:0]       cmd_addr,
    input  wire [`ROW_IDX_W-1:0]    cmd_col,
    input  wire [`WORD_W-1:0]       cmd_row_data,
    input  wire [`CACHE_ROWS-1:0]   cmd_col_data,
    output wire                     cmd_ready,
    output wire                     rsp_valid,
    output wire [`WORD_W-1:0]       rsp_row,
    output wire [`CACHE_ROWS-1:0]   rsp_col,
    input  wire                     rsp_ready,
    output wire                     rd_req_valid,
    output wire [`DDR_ADDR_W-1:0]   rd_req_addr,
    input  wire                     rd_req_ready,
    input  wire                     fill_valid,
    input  wire [`WORD_W-1:0]       fill_data,
    output wire                     wb_valid,
    output wire [`DDR_ADDR_W-1:0]   wb_addr,
    output wire [`WORD_W-1:0]       wb_data,
    input  wire                     wb_ready
);

    wire                            wb_start;
    wire cache_pkg::cache_addr_u    wb_tag;
    wire                            wb_done;
    wire                            wr_row_en;
    wire [`ROW_IDX_W-1:0]           wr_row_idx;
    wire [`WORD_W-1:0]              wr_row_data;
    wire                            wr_col_en;
    wire [`ROW_IDX_W-1:0]           wr_col_idx;
    wire [`CACHE_ROWS-1:0]          wr_col_data;
    wire [`ROW_IDX_W-1:0]           rd_row_idx;
    wire [`ROW_IDX_W-1:0]           rd_col_idx;
    wire [`WORD_W-1:0]              rd_row_data;
    wire [`CACHE_ROWS-1:0]          rd_col_data;
    wire                            wb_rd_en;
    wire [`ROW_IDX_W-1:0]           wb_rd_idx;
    wire [`WORD_W-1:0]              wb_rd_data;

    cache_ctrl cache_ctrl_i (
        .clk          (clk),
        .rst          (rst),
        .cmd_valid    (cmd_valid),
        .cmd_op       (cmd_op),
        .cmd_addr     (cmd_addr),
        .cmd_col      (cmd_col),
        .cmd_row_data (cmd_row_data),
        .cmd_col_data (cmd_col_data),
        .cmd_ready    (cmd_ready),
        .rsp_valid    (rsp_valid),
        .rsp_row      (rsp_row),
        .rsp_col      (rsp_col),
        .rsp_ready    (rsp_ready),
        .rd_req_valid (rd_req_valid),
        .rd_req_addr  (rd_req_addr),
        .rd_req_ready (rd_req_ready),
        .fill_valid   (fill_valid),
        .fill_data    (fill_data),
        .wb_start     (wb_start),
        .wb_tag       (wb_tag),
        .wb_done      (wb_done),
        .wr_row_en    (wr_row_en),
        .wr_row_idx   (wr_row_idx),
        .wr_row_data  (wr_row_data),
        .wr_col_en    (wr_col_en),
        .wr_col_idx   (wr_col_idx),
        .wr_col_data  (wr_col_data),
        .rd_row_idx   (rd_row_idx),
        .rd_col_idx   (rd_col_idx),
        .rd_row_data  (rd_row_data),
        .rd_col_data  (rd_col_data)
    );

    tile_mem tile_mem_i (
        .clk          (clk),
        .wr_row_en    (wr_row_en),
        .wr_row_idx   (wr_row_idx),
        .wr_row_data  (wr_row_data),
        .wr_col_en    (wr_col_en),
        .wr_col_idx   (wr_col_idx),
        .wr_col_data  (wr_col_data),
        .rd_row_idx   (rd_row_idx),
        .rd_col_idx   (rd_col_idx),
        .wb_rd_en     (wb_rd_en),
        .wb_rd_idx    (wb_rd_idx),
        .rd_row_data  (rd_row_data),
        .rd_col_data  (rd_col_data),
        .wb_rd_data   (wb_rd_data)
    );

    ddr_writeback ddr_writeback_i (
        .clk          (clk),
        .rst          (rst),
        .wb_start     (wb_start),
        .wb_tag       (wb_tag),
        .wb_rd_data   (wb_rd_data),
        .wb_ready     (wb_ready),
        .wb_rd_en     (wb_rd_en),
        .wb_rd_idx    (wb_rd_idx),
        .wb_valid     (wb_valid),
        .wb_addr      (wb_addr),
        .wb_data      (wb_data),
        .wb_done      (wb_done)
    );

endmodule

`default_nettype wire

/* tests/data_cache_props.sv */
`timescale 1ns/1ps
`default_nettype none

`include "cache_settings.svh"

module data_cache_props (
    input wire                     clk,
    input wire                     rst,
    input wire                     rsp_valid,
    input wire                     rsp_ready,
    input wire [`WORD_W-1:0]       rsp_row,
    input wire [`CACHE_ROWS-1:0]   rsp_col,
    input wire                     wb_valid,
    input wire                     wb_ready,
    input wire [`DDR_ADDR_W-1:0]   wb_addr,
    input wire [`WORD_W-1:0]       wb_data,
    input wire                     rd_req_valid,
    input wire                     rd_req_ready
);

    logic out_of_reset;    // Low until the first edge with reset released.

    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            out_of_reset <= 1'b0;
        end else begin
            out_of_reset <= 1'b1;
        end
    end

    rsp_hold: assert property (@(posedge clk) disable iff (!rst)
        rsp_valid && !rsp_ready |=> rsp_valid && $stable(rsp_row) && $stable(rsp_col))
        else $error("response changed while stalled");

    wb_hold: assert property (@(posedge clk) disable iff (!rst)
        wb_valid && !wb_ready |=> wb_valid && $stable(wb_addr) && $stable(wb_data))
        else $error("write-back beat changed while stalled");

    req_hold: assert property (@(posedge clk) disable iff (!rst)
        rd_req_valid && !rd_req_ready |=> rd_req_valid)
        else $error("fill request dropped before acceptance");

    reset_idle: assert property (@(posedge clk)
        rst && !out_of_reset |-> !rsp_valid && !wb_valid && !rd_req_valid)
        else $error("valid output high on the first edge after reset");

endmodule

bind data_cache data_cache_props data_cache_props_i (
    .clk(clk), .rst(rst), .rsp_valid(rsp_valid), .rsp_ready(rsp_ready),
    .rsp_row(rsp_row), .rsp_col(rsp_col), .wb_valid(wb_valid), .wb_ready(wb_ready),
    .wb_addr(wb_addr), .wb_data(wb_data), .rd_req_valid(rd_req_valid),
    .rd_req_ready(rd_req_ready)
);

`default_nettype wire

/* tests/data_cache_tb.sv */
`timescale 1ns/1ps
`default_nettype none

`include "cache_settings.svh"

module data_cache_tb;

    localparam int LIMIT = 2000;

    logic        clk = 1'b0;
    logic        rst = 1'b0;
    logic        cmd_valid = 1'b0;
    logic [2:0]  cmd_op = 3'd0;
    logic [15:0] cmd_addr = 16'h0;
    logic [3:0]  cmd_col = 4'h0;
    logic [15:0] cmd_row_data = 16'h0;
    logic [15:0] cmd_col_data = 16'h0;
    logic        rsp_ready = 1'b1;
    logic        rd_req_ready = 1'b1;
    logic        fill_valid = 1'b0;
    logic [15:0] fill_data = 16'h0;
    logic        wb_ready = 1'b1;
    wire         cmd_ready, rsp_valid, rd_req_valid, wb_valid;
    wire  [15:0] rsp_row, rsp_col, wb_data;
    wire  [27:0] rd_req_addr, wb_addr;

    logic        bp = 1'b0;
    logic [31:0] rnd_bp, rnd_fill;
    int          errors = 0, checks = 0, fill_left = 0, req_count = 0, exp_req = 0;
    logic [15:0] fill_base;
    logic [27:0] last_req_addr, exp_req_addr;
    logic [15:0] ddr_mem [logic [15:0]];
    logic [27:0] got_wb_addr[$], exp_wb_addr[$];
    logic [15:0] got_wb_data[$], exp_wb_data[$];
    logic [15:0] ref_tile [16];
    logic [11:0] ref_tag;
    logic        ref_valid = 1'b0, ref_dirty = 1'b0;

    data_cache data_cache_i (.*);

    initial begin
        forever #20 clk = ~clk;
    end

    function automatic logic [15:0] ddr_word(input logic [15:0] a);
        return ddr_mem.exists(a) ? ddr_mem[a] : (a ^ 16'h5a5a);
    endfunction

    // ######################################################################
    // DDR model and back-pressure
    // ######################################################################

    // Under back-pressure the first cycle of every valid is stalled.
    always @(posedge clk) begin
        rnd_bp = $urandom;
        rsp_ready    <= bp ? (rnd_bp[0] && rsp_valid) : 1'b1;
        wb_ready     <= bp ? (rnd_bp[1] && wb_valid) : 1'b1;
        rd_req_ready <= bp ? (rnd_bp[2] && rd_req_valid) : 1'b1;
    end

    always @(posedge clk) begin
        rnd_fill = $urandom;
        fill_valid <= 1'b0;
        if (fill_left != 0 && rnd_fill[1:0] != 2'd0) begin    // Leaves random gaps.
            fill_valid <= 1'b1;
            fill_data  <= ddr_word(fill_base + 16'(16 - fill_left));
            fill_left  <= fill_left - 1;
        end
        if (rd_req_valid && rd_req_ready) begin
            req_count     <= req_count + 1;
            last_req_addr <= rd_req_addr;
            fill_base     <= rd_req_addr[18:3];
            fill_left     <= 16;
        end
        if (wb_valid && wb_ready) begin
            got_wb_addr.push_back(wb_addr);
            got_wb_data.push_back(wb_data);
        end
    end

    task automatic check(input logic [31:0] got, input logic [31:0] exp, input string msg);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("mismatch at %0t: %s (got %h, expected %h)", $time, msg, got, exp);
        end
    endtask

    task automatic abort_run(input string what);
        $display("timeout: %s did not happen in time", what);
        $display("TEST RESULT: FAIL");
        $finish;
    endtask

    task automatic wait_ready();
        int n;
        n = 0;
        @(posedge clk);
        while (!cmd_ready) begin
            n++;
            if (n > LIMIT) abort_run("cmd_ready");
            @(posedge clk);
        end
    endtask

    // ######################################################################
    // One command with its reference model update and checks
    // ######################################################################

    task automatic do_cmd(input logic [2:0] op, input logic [15:0] addr, input logic [3:0] col,
                          input logic [15:0] rd, input logic [15:0] cd, output int latency);
        logic [11:0] tag;
        logic [3:0]  row;
        logic [15:0] exp_row, exp_col;
        int          n;
        tag = addr[15:4];
        row = addr[3:0];
        latency = -1;
        if (ref_valid && ref_dirty && (op == `OP_FLUSH || tag != ref_tag)) begin
            for (int r = 0; r < 16; r++) begin
                exp_wb_addr.push_back(28'({ref_tag, 4'(r)}) << 3);
                exp_wb_data.push_back(ref_tile[r]);
                ddr_mem[{ref_tag, 4'(r)}] = ref_tile[r];
            end
            ref_dirty = 1'b0;
        end
        if (op != `OP_FLUSH && !(ref_valid && tag == ref_tag)) begin
            for (int r = 0; r < 16; r++) ref_tile[r] = ddr_word({tag, 4'(r)});
            ref_valid = 1'b1;
            ref_tag = tag;
            exp_req++;
            exp_req_addr = 28'({tag, 4'h0}) << 3;
        end
        if (op == `OP_ROW_WRITE) begin
            ref_tile[row] = rd;
            ref_dirty = 1'b1;
        end
        if (op == `OP_COL_WRITE) begin
            for (int r = 0; r < 16; r++) ref_tile[r][col] = cd[r];
            ref_dirty = 1'b1;
        end
        exp_row = ref_tile[row];
        for (int r = 0; r < 16; r++) exp_col[r] = ref_tile[r][col];

        @(posedge clk);
        cmd_valid    <= 1'b1;
        cmd_op       <= op;
        cmd_addr     <= addr;
        cmd_col      <= col;
        cmd_row_data <= rd;
        cmd_col_data <= cd;
        wait_ready();
        cmd_valid <= 1'b0;
        if (op == `OP_ROW_READ || op == `OP_COL_READ) begin
            n = 1;
            @(posedge clk);
            while (!(rsp_valid && rsp_ready)) begin
                if (rsp_valid && latency < 0) latency = n - 1;
                n++;
                if (n > LIMIT) abort_run("rsp_valid");
                @(posedge clk);
            end
            if (latency < 0) latency = n - 1;    // Edge that raised rsp_valid.
            if (op == `OP_ROW_READ) check(32'(rsp_row), 32'(exp_row), "row read data");
            else check(32'(rsp_col), 32'(exp_col), "column read data");
        end else begin
            wait_ready();
        end
        check(32'(req_count), 32'(exp_req), "fill request count");
        if (exp_req > 0) check(32'(last_req_addr), 32'(exp_req_addr), "fill request address");
        check(32'(got_wb_addr.size()), 32'(exp_wb_addr.size()), "write-back beat count");
        if (got_wb_addr.size() == exp_wb_addr.size()) begin
            foreach (exp_wb_addr[i]) begin
                check(32'(got_wb_addr[i]), 32'(exp_wb_addr[i]), "write-back address");
                check(32'(got_wb_data[i]), 32'(exp_wb_data[i]), "write-back data");
            end
        end
        got_wb_addr.delete();
        got_wb_data.delete();
        exp_wb_addr.delete();
        exp_wb_data.delete();
    endtask

    task automatic report(input string name);
        $display("test %s finished, %0d errors so far", name, errors);
    endtask

    // ######################################################################
    // Directed tests
    // ######################################################################

    task automatic test_first_read();
        int lat;
        do_cmd(`OP_ROW_READ, 16'h0123, 4'h0, 16'h0, 16'h0, lat);
        check(32'(last_req_addr), 32'h0000_0900, "first fill address");    // 0x0120 << 3.
        report("first_read");
    endtask

    task automatic test_row_write_read();
        int lat;
        logic [31:0] v;
        v = $urandom;
        do_cmd(`OP_ROW_WRITE, 16'h0125, 4'h0, v[15:0], 16'h0, lat);
        do_cmd(`OP_ROW_READ, 16'h0125, 4'h0, 16'h0, 16'h0, lat);
        check(32'(lat), 32'd2, "read hit latency");
        report("row_write_read");
    endtask

    task automatic test_column();
        int lat;
        logic [31:0] v;
        v = $urandom;
        do_cmd(`OP_COL_WRITE, 16'h0120, 4'd5, 16'h0, v[15:0], lat);
        do_cmd(`OP_COL_READ, 16'h0120, 4'd5, 16'h0, 16'h0, lat);
        for (int r = 0; r < 16; r++) begin
            do_cmd(`OP_ROW_READ, {12'h012, 4'(r)}, 4'h0, 16'h0, 16'h0, lat);
        end
        report("column");
    endtask

    task automatic test_dirty_miss();
        int lat;
        do_cmd(`OP_ROW_READ, 16'h0a37, 4'h0, 16'h0, 16'h0, lat);
        report("dirty_miss");
    endtask

    task automatic test_flush_bp();
        int lat;
        logic [31:0] v;
        bp <= 1'b1;
        v = $urandom;
        do_cmd(`OP_ROW_WRITE, 16'h0a31, 4'h0, v[15:0], 16'h0, lat);
        do_cmd(`OP_COL_WRITE, 16'h0a30, 4'd9, 16'h0, v[31:16], lat);
        do_cmd(`OP_ROW_READ, 16'h0a31, 4'h0, 16'h0, 16'h0, lat);
        do_cmd(`OP_FLUSH, 16'h0a30, 4'h0, 16'h0, 16'h0, lat);
        do_cmd(`OP_FLUSH, 16'h0a30, 4'h0, 16'h0, 16'h0, lat);    // Clean now, so no beats.
        do_cmd(`OP_ROW_READ, 16'h0b52, 4'h0, 16'h0, 16'h0, lat);    // Stalled fill request.
        bp <= 1'b0;
        report("flush_bp");
    endtask

    initial begin
        void'($urandom(32'hacdd));
        repeat (2) @(posedge clk);
        rst <= 1'b1;
        test_first_read();
        test_row_write_read();
        test_column();
        test_dirty_miss();
        test_flush_bp();
        $display("%0d checks, %0d errors", checks, errors);
        if (errors == 0) begin
            $display("TEST RESULT: PASS");
        end else begin
            $display("TEST RESULT: FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* build.f */
+incdir+common
common/cache_pkg.sv
cache/tile_mem.sv
cache/ddr_writeback.sv
cache/cache_ctrl.sv
hdl/data_cache.sv
tests/data_cache_props.sv
tests/data_cache_tb.sv

/* run.sh */
#!/bin/bash
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert \
    -f build.f \
    --top-module data_cache_tb \
    -o data_cache_sim

out=$(./obj_dir/data_cache_sim)
echo "$out"
echo "$out" | grep -q "TEST RESULT: PASS"
